// File: source/isa_pkg.sv
package isa_pkg;

    typedef logic [7:0] word_t;      // data, address or instruction byte
    typedef logic [1:0] reg_idx_t;   // r0..r3

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_MOV  = 4'd1,   // ra <- rb
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_NOT  = 4'd6,   // ra <- ~rb
        OP_IN   = 4'd7,   // ra <- in_port
        OP_OUT  = 4'd8,   // out_port <- rb
        OP_JMP  = 4'd9,   // pc <- rb
        OP_LD   = 4'd10,  // ra <- mem[rb]
        OP_ST   = 4'd11,  // mem[rb] <- ra
        OP_LDM  = 4'd12,  // ra <- next byte
        OP_HALT = 4'd15
    } opcode_e;           // 13, 14 fall through as nop

    // one instruction byte split into its fields
    typedef struct packed {
        opcode_e  op;     // bits 7..4
        reg_idx_t ra;     // bits 3..2
        reg_idx_t rb;     // bits 1..0
    } instr_t;

endpackage

// File: source/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_PASS_B,      // mov, out, ld/st address
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_PASS_IMM     // in, ldm
    } alu_op_e;

    // decoded control, all zero is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;    // operand b from imm
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    io_write;   // out instruction
        logic    is_jump;
    } ctrl_t;

    typedef struct packed {
        ctrl_t              ctrl;
        isa_pkg::reg_idx_t  ra;       // source fields for forwarding
        isa_pkg::reg_idx_t  rb;
        isa_pkg::reg_idx_t  dest;
        isa_pkg::word_t     ra_val;
        isa_pkg::word_t     rb_val;
        isa_pkg::word_t     imm;      // in_port or ldm byte
    } id_ex_t;

    typedef struct packed {
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
        logic               io_write;
        isa_pkg::reg_idx_t  dest;
        isa_pkg::word_t     alu_res;    // result or memory address
        isa_pkg::word_t     store_val;  // R[ra] for st
    } ex_mem_t;

    typedef struct packed {
        logic               reg_write;
        logic               io_write;
        isa_pkg::reg_idx_t  dest;
        isa_pkg::word_t     wb_val;
    } mem_wb_t;

    typedef enum logic [1:0] {
        FWD_REG,     // value read in decode
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

endpackage

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::reg_idx_t rd_a,
    input  isa_pkg::reg_idx_t rd_b,
    output isa_pkg::word_t    val_a,
    output isa_pkg::word_t    val_b,
    input  logic              wr_en,
    input  isa_pkg::reg_idx_t wr_idx,
    input  isa_pkg::word_t    wr_data
);

    isa_pkg::word_t regs_q [4];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs_q <= '{default: '0};           // r0..r3 start at zero
        end else if (wr_en) begin
            regs_q[wr_idx] <= wr_data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign val_a = (wr_en && wr_idx == rd_a) ? wr_data : regs_q[rd_a];
    assign val_b = (wr_en && wr_idx == rd_b) ? wr_data : regs_q[rd_b];

endmodule

// File: source/unified_mem.sv
`timescale 1ns/1ps

module unified_mem #(
    parameter int MEM_DEPTH = 256
) (
    input  logic           clk,
    input  logic           rst_n,        // only watched by the loader check
    input  isa_pkg::word_t fetch_addr,   // port a, instructions
    output isa_pkg::word_t fetch_data,
    input  isa_pkg::word_t data_addr,    // port b, load/store
    input  isa_pkg::word_t write_data,
    input  logic           write_en,
    output isa_pkg::word_t read_data,
    input  logic           load_en,
    input  isa_pkg::word_t load_addr,
    input  isa_pkg::word_t load_data
);

    localparam int AW = $clog2(MEM_DEPTH);   // upper address bits wrap

    isa_pkg::word_t mem [MEM_DEPTH];

    assign fetch_data = mem[fetch_addr[AW-1:0]];   // async reads
    assign read_data  = mem[data_addr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (load_en) begin                          // loader wins port b
            mem[load_addr[AW-1:0]] <= load_data;
        end else if (write_en) begin
            mem[data_addr[AW-1:0]] <= write_data;   // st
        end
    end

    // program image goes in only while the core sits in reset
    a_load_in_reset: assert property (@(posedge clk) load_en |-> !rst_n)
        else $error("load_en raised while core running");

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,        // load-use
    input  logic           flush,        // jump taken
    input  logic           freeze,       // after halt
    input  logic           jump_en,
    input  isa_pkg::word_t jump_target,
    output isa_pkg::word_t fetch_addr,
    input  isa_pkg::word_t fetch_data,
    output isa_pkg::word_t if_instr,     // IF/ID
    output logic           if_valid
);

    isa_pkg::word_t pc_q;
    isa_pkg::word_t pc_next;
    logic           hold;

    assign fetch_addr = pc_q;
    assign hold       = stall || freeze;
    assign pc_next    = jump_en ? jump_target : pc_q + 8'd1;   // no other pc source

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q     <= '0;             // first fetch from address 0
            if_valid <= 1'b0;
        end else if (flush) begin
            pc_q     <= pc_next;        // redirect to target
            if_valid <= 1'b0;           // kill slot behind jmp
        end else if (!hold) begin
            pc_q     <= pc_next;
            if_instr <= fetch_data;
            if_valid <= 1'b1;
        end
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::word_t    if_instr,
    input  logic              if_valid,
    input  logic              stall,
    input  logic              flush,
    input  isa_pkg::word_t    in_port,   // sampled as IN leaves decode
    input  pipe_pkg::mem_wb_t wb,        // register write-back
    output pipe_pkg::id_ex_t  id_ex,
    output logic              halt
);

    typedef enum logic {
        ST_NORMAL,
        ST_AWAIT_IMM      // IF/ID holds the LDM data byte
    } state_e;

    state_e             state_q;
    isa_pkg::reg_idx_t  ldm_dest_q;   // ra of the pending LDM
    isa_pkg::instr_t    instr;
    isa_pkg::word_t     ra_val, rb_val;
    pipe_pkg::ctrl_t    ctrl;
    pipe_pkg::id_ex_t   id_ex_d;

    assign instr = isa_pkg::instr_t'(if_instr);
    assign halt  = if_valid && state_q == ST_NORMAL && instr.op == isa_pkg::OP_HALT;

    register_file u_rf (
        .clk(clk), .rst_n(rst_n),
        .rd_a(instr.ra), .rd_b(instr.rb), .val_a(ra_val), .val_b(rb_val),
        .wr_en(wb.reg_write), .wr_idx(wb.dest), .wr_data(wb.wb_val)
    );

    always_comb begin
        ctrl = '0;                                   // nop, ldm byte 1, halt
        if (state_q == ST_AWAIT_IMM) begin
            ctrl.alu_op    = pipe_pkg::ALU_PASS_IMM; // ldm write
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
        end else begin
            case (instr.op)
                isa_pkg::OP_MOV: ctrl.reg_write = 1'b1;   // pass-b is 0
                isa_pkg::OP_ADD: begin
                    ctrl.alu_op    = pipe_pkg::ALU_ADD;
                    ctrl.reg_write = 1'b1;
                end
                isa_pkg::OP_SUB: begin
                    ctrl.alu_op    = pipe_pkg::ALU_SUB;
                    ctrl.reg_write = 1'b1;
                end
                isa_pkg::OP_AND: begin
                    ctrl.alu_op    = pipe_pkg::ALU_AND;
                    ctrl.reg_write = 1'b1;
                end
                isa_pkg::OP_OR: begin
                    ctrl.alu_op    = pipe_pkg::ALU_OR;
                    ctrl.reg_write = 1'b1;
                end
                isa_pkg::OP_NOT: begin
                    ctrl.alu_op    = pipe_pkg::ALU_NOT;
                    ctrl.reg_write = 1'b1;
                end
                isa_pkg::OP_IN: begin
                    ctrl.alu_op    = pipe_pkg::ALU_PASS_IMM;
                    ctrl.use_imm   = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
                isa_pkg::OP_OUT: ctrl.io_write  = 1'b1;   // emits rb
                isa_pkg::OP_JMP: ctrl.is_jump   = 1'b1;
                isa_pkg::OP_LD: begin
                    ctrl.mem_read  = 1'b1;               // address is rb
                    ctrl.reg_write = 1'b1;
                end
                isa_pkg::OP_ST:  ctrl.mem_write = 1'b1;
                default: ;                               // nop, ldm, halt, 13, 14
            endcase
        end
    end

    always_comb begin
        id_ex_d.ctrl   = if_valid ? ctrl : '0;
        id_ex_d.ra     = instr.ra;
        id_ex_d.rb     = instr.rb;
        id_ex_d.dest   = (state_q == ST_AWAIT_IMM) ? ldm_dest_q : instr.ra;
        id_ex_d.ra_val = ra_val;
        id_ex_d.rb_val = rb_val;
        id_ex_d.imm    = (state_q == ST_AWAIT_IMM) ? if_instr : in_port;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            state_q <= ST_NORMAL;
        end else if (if_valid && !stall) begin
            case (state_q)
                ST_NORMAL: if (instr.op == isa_pkg::OP_LDM) begin
                    state_q    <= ST_AWAIT_IMM;
                    ldm_dest_q <= instr.ra;
                end
                default: state_q <= ST_NORMAL;   // data byte consumed
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush || stall) begin
            id_ex <= '0;                         // bubble
        end else begin
            id_ex <= id_ex_d;
        end
    end

    // data byte sits right behind the LDM so the wait never stretches
    a_await_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        state_q == ST_AWAIT_IMM |=> state_q == ST_NORMAL)
        else $error("await-immediate held past the LDM data byte");

endmodule

// File: source/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  isa_pkg::word_t   if_instr,   // instruction in decode
    input  logic             if_valid,
    input  pipe_pkg::id_ex_t id_ex,      // instruction in execute
    input  logic             jump_en,
    input  logic             halt,
    output logic             stall,
    output logic             flush,
    output logic             freeze
);

    isa_pkg::instr_t instr;
    logic            reads_ra, reads_rb;

    assign instr = isa_pkg::instr_t'(if_instr);

    always_comb begin
        reads_ra = instr.op inside {isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND,
                                    isa_pkg::OP_OR, isa_pkg::OP_ST};
        reads_rb = reads_ra || instr.op inside {isa_pkg::OP_MOV, isa_pkg::OP_NOT,
                                                isa_pkg::OP_OUT, isa_pkg::OP_JMP,
                                                isa_pkg::OP_LD};
    end

    // no false stall on an ldm data byte since id_ex then holds the ldm bubble
    assign stall  = if_valid && id_ex.ctrl.mem_read &&
                    ((reads_ra && id_ex.dest == instr.ra) || (reads_rb && id_ex.dest == instr.rb));
    assign flush  = jump_en;
    assign freeze = halt && !jump_en;   // halt stays in IF/ID so this holds until reset

    always_comb begin
        a_no_stall_with_flush: assert final (!(stall && flush))
            else $error("stall and flush raised together");
    end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::id_ex_t  id_ex,
    input  pipe_pkg::mem_wb_t wb,
    output pipe_pkg::ex_mem_t ex_mem,
    output logic              jump_en,
    output isa_pkg::word_t    jump_target
);

    pipe_pkg::fwd_sel_e sel_a, sel_b;
    isa_pkg::word_t     a_val, b_val;   // forwarded register values
    isa_pkg::word_t     op_b;
    isa_pkg::word_t     alu_res;

    // loads in EX/MEM have no data yet, the stall covers them
    function automatic pipe_pkg::fwd_sel_e pick_src(isa_pkg::reg_idx_t src,
                                                    pipe_pkg::ex_mem_t em,
                                                    pipe_pkg::mem_wb_t mw);
        if (em.reg_write && !em.mem_read && em.dest == src) return pipe_pkg::FWD_EXMEM;
        if (mw.reg_write && mw.dest == src) return pipe_pkg::FWD_MEMWB;
        return pipe_pkg::FWD_REG;
    endfunction

    function automatic isa_pkg::word_t fwd_val(pipe_pkg::fwd_sel_e sel,
                                               isa_pkg::word_t reg_val,
                                               isa_pkg::word_t em_val,
                                               isa_pkg::word_t mw_val);
        case (sel)
            pipe_pkg::FWD_EXMEM: return em_val;
            pipe_pkg::FWD_MEMWB: return mw_val;
            default:             return reg_val;
        endcase
    endfunction

    assign sel_a = pick_src(id_ex.ra, ex_mem, wb);   // newest writer wins
    assign sel_b = pick_src(id_ex.rb, ex_mem, wb);
    assign a_val = fwd_val(sel_a, id_ex.ra_val, ex_mem.alu_res, wb.wb_val);
    assign b_val = fwd_val(sel_b, id_ex.rb_val, ex_mem.alu_res, wb.wb_val);
    assign op_b  = id_ex.ctrl.use_imm ? id_ex.imm : b_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            pipe_pkg::ALU_ADD: alu_res = a_val + op_b;   // wraps mod 256
            pipe_pkg::ALU_SUB: alu_res = a_val - op_b;
            pipe_pkg::ALU_AND: alu_res = a_val & op_b;
            pipe_pkg::ALU_OR:  alu_res = a_val | op_b;
            pipe_pkg::ALU_NOT: alu_res = ~op_b;
            default:           alu_res = op_b;           // pass-b, pass-imm
        endcase
    end

    assign jump_en     = id_ex.ctrl.is_jump;   // resolved here, two slots lost
    assign jump_target = b_val;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.reg_write <= id_ex.ctrl.reg_write;
            ex_mem.mem_read  <= id_ex.ctrl.mem_read;
            ex_mem.mem_write <= id_ex.ctrl.mem_write;
            ex_mem.io_write  <= id_ex.ctrl.io_write;
            ex_mem.dest      <= id_ex.dest;
            ex_mem.alu_res   <= alu_res;
            ex_mem.store_val <= a_val;                // st writes R[ra]
        end
    end

endmodule

// File: source/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::ex_mem_t ex_mem,
    input  isa_pkg::word_t    read_data,    // port b, async
    output isa_pkg::word_t    data_addr,
    output isa_pkg::word_t    write_data,
    output logic              write_en,
    output pipe_pkg::mem_wb_t wb,
    output isa_pkg::word_t    out_port,
    output logic              out_valid
);

    assign data_addr  = ex_mem.alu_res;     // address from rb
    assign write_data = ex_mem.store_val;
    assign write_en   = ex_mem.mem_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.reg_write <= ex_mem.reg_write;
            wb.io_write  <= ex_mem.io_write;
            wb.dest      <= ex_mem.dest;
            wb.wb_val    <= ex_mem.mem_read ? read_data : ex_mem.alu_res;
        end
    end

    assign out_valid = wb.io_write;                  // one pulse per out
    assign out_port  = wb.io_write ? wb.wb_val : '0; // zero between pulses

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter int MEM_DEPTH = 256    // bytes, power of two
) (
    input  logic           clk,
    input  logic           rst_n,
    input  isa_pkg::word_t in_port,
    input  logic           load_en,    // program loader, reset only
    input  isa_pkg::word_t load_addr,
    input  isa_pkg::word_t load_data,
    output isa_pkg::word_t out_port,
    output logic           out_valid   // one-cycle pulse per out
);

    isa_pkg::word_t     fetch_addr, fetch_data;     // port a
    isa_pkg::word_t     data_addr, write_data;      // port b
    isa_pkg::word_t     read_data;
    logic               write_en;
    isa_pkg::word_t     if_instr;
    logic               if_valid;
    logic               stall, flush, freeze, halt;
    logic               jump_en;
    isa_pkg::word_t     jump_target;
    pipe_pkg::id_ex_t   id_ex;
    pipe_pkg::ex_mem_t  ex_mem;
    pipe_pkg::mem_wb_t  wb;

    unified_mem #(.MEM_DEPTH(MEM_DEPTH)) u_mem (
        .clk(clk), .rst_n(rst_n),
        .fetch_addr(fetch_addr), .fetch_data(fetch_data),
        .data_addr(data_addr), .write_data(write_data),
        .write_en(write_en), .read_data(read_data),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
    );

    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n),
        .stall(stall), .flush(flush), .freeze(freeze),
        .jump_en(jump_en), .jump_target(jump_target),
        .fetch_addr(fetch_addr), .fetch_data(fetch_data),
        .if_instr(if_instr), .if_valid(if_valid)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n),
        .if_instr(if_instr), .if_valid(if_valid),
        .stall(stall), .flush(flush),
        .in_port(in_port), .wb(wb),
        .id_ex(id_ex), .halt(halt)
    );

    hazard_unit u_hazard (
        .if_instr(if_instr), .if_valid(if_valid), .id_ex(id_ex),
        .jump_en(jump_en), .halt(halt),
        .stall(stall), .flush(flush), .freeze(freeze)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n),
        .id_ex(id_ex), .wb(wb), .ex_mem(ex_mem),
        .jump_en(jump_en), .jump_target(jump_target)
    );

    writeback_stage u_writeback (
        .clk(clk), .rst_n(rst_n),
        .ex_mem(ex_mem), .read_data(read_data),
        .data_addr(data_addr), .write_data(write_data), .write_en(write_en),
        .wb(wb), .out_port(out_port), .out_valid(out_valid)
    );

endmodule

// File: dv/cpu_tests.svh
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

// dependent ops back to back reach EX through both forward paths
task automatic alu_chain();
    isa_pkg::word_t a, b, sum, diff, anded, ored;
    isa_pkg::word_t prog[$];
    isa_pkg::word_t exp[$];
    a     = lcg_next();
    b     = lcg_next();
    sum   = a + b;            // wraps at 8 bits
    diff  = b - sum;
    anded = sum & diff;
    ored  = diff | a;
    prog  = '{encode(isa_pkg::OP_LDM, 0, 0), a,
              encode(isa_pkg::OP_LDM, 1, 0), b,
              encode(isa_pkg::OP_MOV, 2, 0),     // r2 = a
              encode(isa_pkg::OP_ADD, 2, 1), encode(isa_pkg::OP_OUT, 0, 2),
              encode(isa_pkg::OP_SUB, 1, 2), encode(isa_pkg::OP_OUT, 0, 1),
              encode(isa_pkg::OP_AND, 2, 1), encode(isa_pkg::OP_OUT, 0, 2),
              encode(isa_pkg::OP_OR,  1, 0), encode(isa_pkg::OP_OUT, 0, 1),
              encode(isa_pkg::OP_NOT, 3, 2), encode(isa_pkg::OP_OUT, 0, 3),
              encode(isa_pkg::OP_HALT, 0, 0)};
    exp   = '{sum, diff, anded, ored, ~anded};
    run_program("alu_chain", prog, exp, 20);
endtask

// ld right after st and out right after ld for the load-use stall
task automatic mem_round_trip();
    isa_pkg::word_t v;
    isa_pkg::word_t prog[$];
    isa_pkg::word_t exp[$];
    v    = lcg_next();
    prog = '{encode(isa_pkg::OP_LDM, 0, 0), v,
             encode(isa_pkg::OP_LDM, 1, 0), 8'hE0,   // data address past the code
             encode(isa_pkg::OP_ST,  0, 1),
             encode(isa_pkg::OP_LD,  2, 1),
             encode(isa_pkg::OP_OUT, 0, 2),
             encode(isa_pkg::OP_HALT, 0, 0)};
    exp  = '{v};
    run_program("mem_round_trip", prog, exp, 20);
endtask

task automatic input_echo();
    isa_pkg::word_t v;
    isa_pkg::word_t prog[$];
    isa_pkg::word_t exp[$];
    v = lcg_next();
    @(posedge clk);
    in_port <= v;                                      // steady for the whole run
    prog = '{encode(isa_pkg::OP_IN,  1, 0),
             encode(isa_pkg::OP_MOV, 3, 1),
             encode(isa_pkg::OP_OUT, 0, 1),
             encode(isa_pkg::OP_OUT, 0, 3),
             encode(isa_pkg::OP_HALT, 0, 0)};
    exp  = '{v, v};
    run_program("input_port", prog, exp, 20);
endtask

// the two slots behind the jmp hold outs that must stay dead
task automatic jump_over();
    isa_pkg::word_t a;
    isa_pkg::word_t prog[$];
    isa_pkg::word_t exp[$];
    a    = lcg_next();
    prog = '{encode(isa_pkg::OP_LDM, 1, 0), 8'd8,    // target
             encode(isa_pkg::OP_LDM, 2, 0), a,
             encode(isa_pkg::OP_JMP, 0, 1),
             encode(isa_pkg::OP_OUT, 0, 2),
             encode(isa_pkg::OP_OUT, 0, 1),
             encode(isa_pkg::OP_HALT, 0, 0),
             encode(isa_pkg::OP_OUT, 0, 2),          // address 8
             encode(isa_pkg::OP_ADD, 2, 2),
             encode(isa_pkg::OP_OUT, 0, 2),
             encode(isa_pkg::OP_HALT, 0, 0)};
    exp  = '{a, a + a};
    run_program("jump", prog, exp, 20);
endtask

task automatic halt_and_rerun();
    isa_pkg::word_t v;
    isa_pkg::word_t prog[$];
    isa_pkg::word_t exp[$];
    v    = lcg_next();
    prog = '{encode(isa_pkg::OP_LDM, 0, 0), v,
             encode(isa_pkg::OP_OUT, 0, 0),
             encode(isa_pkg::OP_HALT, 0, 0),
             encode(isa_pkg::OP_OUT, 0, 0),          // never reached
             encode(isa_pkg::OP_HALT, 0, 0)};
    exp  = '{v};
    run_program("halt", prog, exp, 50);
    run_program("halt_rerun", prog, exp, 50);        // reset clears the freeze
endtask

`endif

// File: dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int RESET_CYCLES    = 5;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST;
    localparam int WAIT_LIMIT      = 150;   // cycles per program for the outputs to show

    logic           clk;
    logic           rst_n;
    isa_pkg::word_t in_port;
    logic           load_en;
    isa_pkg::word_t load_addr;
    isa_pkg::word_t load_data;
    isa_pkg::word_t out_port;
    logic           out_valid;

    isa_pkg::word_t outputs[$];   // every out_port seen with out_valid
    string          test_name   = "";
    int             errors      = 0;
    int             checks      = 0;
    int             cycle_count = 0;
    int unsigned    lcg_state   = 25;

    cpu_top #(.MEM_DEPTH(256)) dut (
        .clk(clk), .rst_n(rst_n), .in_port(in_port),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .out_port(out_port), .out_valid(out_valid)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;   // 8 ns period

    function automatic isa_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];   // middle bits since the low ones cycle fast
    endfunction

    // packs op, ra and rb into one instruction byte
    function automatic isa_pkg::word_t encode(isa_pkg::opcode_e op, isa_pkg::reg_idx_t ra,
                                              isa_pkg::reg_idx_t rb);
        return {op, ra, rb};
    endfunction

    task automatic check_word(input string name, input isa_pkg::word_t exp,
                              input isa_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected 0x%h, actual 0x%h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s output count: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // holds the core in reset and writes the image through the loader port
    task automatic load_program(input isa_pkg::word_t prog[$]);
        int cycles;
        int i;
        cycles = (prog.size() > RESET_CYCLES) ? prog.size() : RESET_CYCLES;
        @(posedge clk);
        rst_n <= 1'b0;
        for (i = 0; i < cycles; i++) begin
            if (i < prog.size()) begin
                load_en   <= 1'b1;
                load_addr <= isa_pkg::word_t'(i);
                load_data <= prog[i];
            end else begin
                load_en <= 1'b0;
            end
            @(posedge clk);
        end
        load_en <= 1'b0;
        rst_n   <= 1'b1;      // fetch of address 0 starts next edge
        outputs.delete();
    endtask

    task automatic run_program(input string name, input isa_pkg::word_t prog[$],
                               input isa_pkg::word_t exp[$], input int settle);
        int waited;
        int n;
        int i;
        load_program(prog);
        test_name = name;
        waited = 0;
        while (outputs.size() < exp.size() && waited < WAIT_LIMIT) begin
            @(negedge clk);                   // monitor pushes on the rising edge
            waited++;
        end
        if (outputs.size() < exp.size()) begin
            errors++;
            $display("%s: expected outputs did not arrive within %0d cycles", name, WAIT_LIMIT);
        end
        repeat (settle) @(negedge clk);   // catch any extra pulse
        check_count(name, exp.size(), outputs.size());
        n = (exp.size() < outputs.size()) ? exp.size() : outputs.size();
        for (i = 0; i < n; i++) begin
            check_word(name, exp[i], outputs[i]);
        end
    endtask

    `include "cpu_tests.svh"

    // values sampled before this edge's updates land
    always @(posedge clk) begin
        if (out_valid) begin
            outputs.push_back(out_port);
        end else if (rst_n) begin
            check_word({test_name, " idle out_port"}, '0, out_port);   // zero between pulses
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        rst_n     = 1'b0;
        in_port   = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        alu_chain();
        mem_round_trip();
        input_echo();
        jump_over();
        halt_and_rerun();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+dv
source/isa_pkg.sv
source/pipe_pkg.sv
source/register_file.sv
source/unified_mem.sv
source/fetch_stage.sv
source/decode_stage.sv
source/hazard_unit.sv
source/execute_stage.sv
source/writeback_stage.sv
source/cpu_top.sv
dv/cpu_tb.sv
